// File: logic/conv_pkg.sv
////////////////////////////////////////////////////////////
// signed 8 bit taps and 3x3 windows only
// sums wider than ACC_W wrap silently
////////////////////////////////////////////////////////////
package conv_pkg;

  ////////////////////////////////////////////////////////////
  // datapath widths
  localparam int FEAT_W = 8;
  localparam int PROD_W = 16;
  localparam int ACC_W  = 28;
  localparam int WORD_W = 32;

  typedef logic signed [FEAT_W-1:0] feat_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [WORD_W-1:0]        word_t;

  ////////////////////////////////////////////////////////////
  // window and pipeline shape
  localparam int KERNEL_TAPS = 9;   // one 3x3 window
  localparam int TAP_CNT_W   = $clog2(KERNEL_TAPS);
  localparam int MUL_STAGES  = 3;

  ////////////////////////////////////////////////////////////
  // requantization
  localparam int BIAS_SHIFT   = 6;    // bias x64 in, result /64 out
  localparam int PIX_MAX      = 127;
  localparam int PIX_PER_WORD = 4;
  localparam int PIX_W        = WORD_W / PIX_PER_WORD;
  localparam int PIX_CNT_W    = $clog2(PIX_PER_WORD);

  // buffer between the MAC and the packer
  localparam int ACC_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W     = $clog2(ACC_FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(ACC_FIFO_DEPTH + 1);

  // rides through the multiplier next to the operands
  typedef struct packed {
    logic  valid;
    logic  last;   // ninth tap of a window
    feat_t bias;
  } tap_tag_t;

endpackage

// File: logic/acc_stream_if.sv
////////////////////////////////////////////////////////////
// one window sum plus its bias, valid/ready handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface acc_stream_if;
  import conv_pkg::*;

  logic  valid;
  logic  ready;
  acc_t  sum;    // raw 3x3 window sum
  feat_t bias;   // unscaled bias byte

  modport src (
    output valid,
    output sum,
    output bias,
    input  ready
  );

  modport dst (
    input  valid,
    input  sum,
    input  bias,
    output ready
  );

endinterface

// File: logic/signed_mult_pipe.sv
////////////////////////////////////////////////////////////
// 3 enabled cycles of latency, everything holds while en is low
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module signed_mult_pipe (
  input  logic               clk,
  input  logic               rstn,
  input  logic               en,
  input  conv_pkg::feat_t    a,
  input  conv_pkg::feat_t    b,
  input  conv_pkg::tap_tag_t tag_in,
  output conv_pkg::prod_t    p,
  output conv_pkg::tap_tag_t tag_out
);
  import conv_pkg::*;

  logic [FEAT_W-1:0] a_mag;                 // stage 1
  logic [FEAT_W-1:0] b_mag;
  logic              sign_s1;
  logic              sign_s2;
  tap_tag_t          tag_s1;
  tap_tag_t          tag_s2;
  logic [PROD_W-1:0] pp [FEAT_W];           // gated partial products
  logic [PROD_W-1:0] pair_sum [FEAT_W/2];   // stage 2
  logic [PROD_W-1:0] mag_sum;

  // tag delay line, only the tags carry control state
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tag_s1  <= '0;
      tag_s2  <= '0;
      tag_out <= '0;
    end else if (en) begin
      tag_s1  <= tag_in;
      tag_s2  <= tag_s1;
      tag_out <= tag_s2;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 1 magnitudes and product sign
  // -128 maps to an unsigned 128 which still fits in 8 bits
  always_ff @(posedge clk) begin
    if (en) begin
      a_mag   <= a[FEAT_W-1] ? (~a + 1'b1) : a;
      b_mag   <= b[FEAT_W-1] ? (~b + 1'b1) : b;
      sign_s1 <= a[FEAT_W-1] ^ b[FEAT_W-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2 partial products summed in pairs
  always_comb begin
    for (int i = 0; i < FEAT_W; i++) begin
      pp[i] = b_mag[i] ? (PROD_W'(a_mag) << i) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      for (int k = 0; k < FEAT_W / 2; k++) begin
        pair_sum[k] <= pp[2*k] + pp[2*k+1];
      end
      sign_s2 <= sign_s1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 3 rest of the tree, then the sign goes back on
  always_comb begin
    mag_sum = '0;
    for (int k = 0; k < FEAT_W / 2; k++) begin
      mag_sum = mag_sum + pair_sum[k];
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      p <= sign_s2 ? (~mag_sum + 1'b1) : mag_sum;   // max magnitude 16384
    end
  end

endmodule

// File: logic/mac_pipeline.sv
////////////////////////////////////////////////////////////
// bias is sampled on the ninth tap; windows are counted from reset
// a stalled output freezes the multiplier and drops in_ready
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mac_pipeline (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  output logic             in_ready,
  input  conv_pkg::feat_t  in_feat,
  input  conv_pkg::feat_t  in_weight,
  input  conv_pkg::feat_t  in_bias,
  acc_stream_if.src        acc_out
);
  import conv_pkg::*;

  logic [TAP_CNT_W-1:0] tap_cnt;   // taps accepted in this window
  logic                 tap_last;
  logic                 advance;
  tap_tag_t             tag_in;
  tap_tag_t             tag_out;
  prod_t                prod;
  acc_t                 accum;
  acc_t                 accum_next;

  // output register empty or leaving this cycle
  assign advance  = !acc_out.valid || acc_out.ready;
  assign in_ready = advance;
  assign tap_last = (tap_cnt == TAP_CNT_W'(KERNEL_TAPS - 1));

  always_comb begin
    tag_in.valid = in_valid;   // in_ready is high whenever en is
    tag_in.last  = tap_last;
    tag_in.bias  = in_bias;
  end

  signed_mult_pipe i_signed_mult_pipe (
    .clk     (clk),
    .rstn    (rstn),
    .en      (advance),
    .a       (in_feat),
    .b       (in_weight),
    .tag_in  (tag_in),
    .p       (prod),
    .tag_out (tag_out)
  );

  assign accum_next = accum + {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};

  ////////////////////////////////////////////////////////////
  // tap counter, accumulator and output valid
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tap_cnt       <= '0;
      accum         <= '0;
      acc_out.valid <= 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
      end
      if (advance) begin
        acc_out.valid <= tag_out.valid && tag_out.last;   // old sum leaves here
        if (tag_out.valid) begin
          accum <= tag_out.last ? '0 : accum_next;
        end
      end
    end
  end

  // finished window sum and its bias
  always_ff @(posedge clk) begin
    if (advance && tag_out.valid && tag_out.last) begin
      acc_out.sum  <= accum_next;
      acc_out.bias <= tag_out.bias;
    end
  end

  // a waiting sum must not move until the FIFO takes it
  a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
    acc_out.valid && !acc_out.ready |=>
      acc_out.valid && $stable(acc_out.sum) && $stable(acc_out.bias));

endmodule

// File: logic/acc_fifo.sv
////////////////////////////////////////////////////////////
// no bypass, a write is seen at the output one cycle later
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module acc_fifo (
  input  logic      clk,
  input  logic      rstn,
  acc_stream_if.dst wr,
  acc_stream_if.src rd
);
  import conv_pkg::*;

  acc_t                  sum_mem  [ACC_FIFO_DEPTH];
  feat_t                 bias_mem [ACC_FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  do_wr;
  logic                  do_rd;

  assign wr.ready = (count != FIFO_CNT_W'(ACC_FIFO_DEPTH));   // low only when full
  assign rd.valid = (count != '0);
  assign rd.sum   = sum_mem[rd_ptr];
  assign rd.bias  = bias_mem[rd_ptr];

  assign do_wr = wr.valid && wr.ready;
  assign do_rd = rd.valid && rd.ready;

  ////////////////////////////////////////////////////////////
  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      sum_mem[wr_ptr]  <= wr.sum;
      bias_mem[wr_ptr] <= wr.bias;
    end
  end

  // pointers wrap at the depth
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(ACC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(ACC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // pointers meeting over stored data means full, a write there overwrites the head
  a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    do_wr |-> !(wr_ptr == rd_ptr && count != '0));

endmodule

// File: logic/requant_packer.sv
////////////////////////////////////////////////////////////
// pixel is 0..127, pixel 0 lands in bits 7:0
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module requant_packer (
  input  logic            clk,
  input  logic            rstn,
  acc_stream_if.dst       acc_in,
  output logic            out_valid,
  input  logic            out_ready,
  output conv_pkg::word_t out_data
);
  import conv_pkg::*;

  acc_t                 total;
  acc_t                 scaled;
  logic [PIX_W-1:0]     pixel;
  logic [PIX_CNT_W-1:0] pix_cnt;   // next free slot in the word
  word_t                word_q;
  logic                 take;

  assign acc_in.ready = !out_valid;   // hold off while a word waits
  assign take         = acc_in.valid && acc_in.ready;

  ////////////////////////////////////////////////////////////
  // bias add and clamp
  assign total  = acc_in.sum + (acc_t'(acc_in.bias) <<< BIAS_SHIFT);
  assign scaled = total >>> BIAS_SHIFT;   // floor divide by 64

  always_comb begin
    if (total[ACC_W-1]) begin
      pixel = '0;                         // negative result
    end else if (scaled > acc_t'(PIX_MAX)) begin
      pixel = PIX_W'(PIX_MAX);
    end else begin
      pixel = scaled[PIX_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // packing
  always_ff @(posedge clk) begin
    if (take) begin
      word_q[pix_cnt*PIX_W +: PIX_W] <= pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pix_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      if (take) begin
        if (pix_cnt == PIX_CNT_W'(PIX_PER_WORD - 1)) begin
          pix_cnt   <= '0;
          out_valid <= 1'b1;              // word complete
        end else begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  assign out_data = word_q;

  a_word_stable: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: logic/conv_mac_core.sv
////////////////////////////////////////////////////////////
// taps in, packed pixel words out, latency depends on stalls
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module conv_mac_core (
  input  logic            clk,
  input  logic            rstn,
  // tap stream
  input  logic            in_valid,
  output logic            in_ready,
  input  conv_pkg::feat_t in_feat,
  input  conv_pkg::feat_t in_weight,
  input  conv_pkg::feat_t in_bias,
  // word stream
  output logic            out_valid,
  input  logic            out_ready,
  output conv_pkg::word_t out_data
);

  acc_stream_if mac_to_fifo ();   // window sums from the MAC
  acc_stream_if fifo_to_rq ();    // buffered sums to the packer

  mac_pipeline i_mac_pipeline (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_feat   (in_feat),
    .in_weight (in_weight),
    .in_bias   (in_bias),
    .acc_out   (mac_to_fifo.src)
  );

  acc_fifo i_acc_fifo (
    .clk  (clk),
    .rstn (rstn),
    .wr   (mac_to_fifo.dst),
    .rd   (fifo_to_rq.src)
  );

  requant_packer i_requant_packer (
    .clk       (clk),
    .rstn      (rstn),
    .acc_in    (fifo_to_rq.dst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// File: verification/tb_conv_mac_core.sv
////////////////////////////////////////////////////////////
// run from the project root so the pattern file path resolves
// out_ready toggles at random once the first two words are out
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_conv_mac_core;
  import conv_pkg::*;

  localparam int BP_START_WORD = 2;   // words taken before back-pressure starts

  logic         clk;
  logic         rstn;
  logic         in_valid;
  logic         in_ready;
  feat_t        in_feat;
  feat_t        in_weight;
  feat_t        in_bias;
  logic         out_valid;
  logic         out_ready;
  word_t        out_data;
  feat_t        tap_feat [$];
  feat_t        tap_weight [$];
  feat_t        tap_bias [$];
  word_t        exp_word [$];
  logic [127:0] word_name [$];
  int           n_words;
  int           main_err;   // pattern file and idle checks
  int           mon_err;    // output side
  int           rcv_cnt;
  bit           loaded;
  logic         held_valid;
  word_t        held_data;

  conv_mac_core i_conv_mac_core (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_feat   (in_feat),
    .in_weight (in_weight),
    .in_bias   (in_bias),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reference pixel from the requantization rule
  function automatic logic [7:0] pixel_of(int sum, int bias);
    int total;
    total = sum + bias * 64;
    if (total < 0) begin
      return 8'd0;
    end else if (total / 64 > 127) begin
      return 8'd127;
    end
    return 8'(total / 64);
  endfunction

  ////////////////////////////////////////////////////////////
  // pattern file, expected words rebuilt from the windows
  task automatic load_patterns();
    int            fd;
    int            sum;
    int            slot;
    logic [7:0]    tok;
    logic [7:0]    val;
    logic [127:0]  name;
    logic [1023:0] rest;
    feat_t         f [KERNEL_TAPS];
    feat_t         b;
    word_t         model;
    word_t         file_word;
    slot  = 0;
    model = '0;
    fd    = $fopen("verification/conv_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      main_err++;
      return;
    end
    while ($fscanf(fd, " %s", tok) == 1) begin
      if (tok == "#") begin
        void'($fgets(rest, fd));   // comment line
      end else if (tok == "w") begin
        sum = 0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
          void'($fscanf(fd, " %h", val));
          f[k] = val;
        end
        for (int k = 0; k < KERNEL_TAPS; k++) begin
          void'($fscanf(fd, " %h", val));
          tap_feat.push_back(f[k]);
          tap_weight.push_back(val);
          sum += int'(f[k]) * int'(feat_t'(val));
        end
        void'($fscanf(fd, " %h", val));
        b = val;
        // only the ninth tap carries the real bias
        for (int k = 0; k < KERNEL_TAPS - 1; k++) begin
          tap_bias.push_back(feat_t'(8'($urandom)));
        end
        tap_bias.push_back(b);
        if (slot < PIX_PER_WORD) begin
          model[slot*8 +: 8] = pixel_of(sum, int'(b));
        end
        slot++;
      end else if (tok == "e") begin
        void'($fscanf(fd, " %s %h", name, file_word));
        if (slot != PIX_PER_WORD || file_word !== model) begin
          $display("error %0s: expected %h actual %h in the pattern file",
                   name, model, file_word);
          main_err++;
        end
        exp_word.push_back(model);
        word_name.push_back(name);
        slot  = 0;
        model = '0;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_taps();
    for (int i = 0; i < tap_feat.size(); i++) begin
      in_valid = 1'b0;
      while (($urandom % 5) == 0) begin   // occasional gap
        @(posedge clk);
        #1;
      end
      in_valid  = 1'b1;
      in_feat   = tap_feat[i];
      in_weight = tap_weight[i];
      in_bias   = tap_bias[i];
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (rstn !== 1'b1) begin
      held_valid = 1'b0;
      rcv_cnt    = 0;
      mon_err    = 0;
    end else begin
      if (held_valid && out_valid !== 1'b1) begin
        $display("a waiting word was withdrawn before it was accepted");
        mon_err++;
      end
      if (held_valid && out_data !== held_data) begin
        $display("error backpressure: expected %h actual %h", held_data, out_data);
        mon_err++;
      end
      held_valid = out_valid && !out_ready;
      held_data  = out_data;
      if (out_valid && out_ready) begin
        if (rcv_cnt >= n_words) begin
          $display("an extra output word %h arrived", out_data);
          mon_err++;
        end else if (out_data !== exp_word[rcv_cnt]) begin
          $display("error %0s: expected %h actual %h",
                   word_name[rcv_cnt], exp_word[rcv_cnt], out_data);
          mon_err++;
        end
        rcv_cnt++;
      end
    end
  end

  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (rcv_cnt < BP_START_WORD) begin
        out_ready = 1'b1;
      end else begin
        out_ready = (($urandom % 2) == 0);   // ready about half the time
      end
    end
  end

  // watchdog, four cycles per tap plus slack
  initial begin
    wait (loaded);
    repeat (tap_feat.size() * 4 + 200) @(posedge clk);
    $display("timeout, only %0d of %0d words arrived", rcv_cnt, n_words);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(57));
    rstn      = 1'b0;
    in_valid  = 1'b0;
    in_feat   = '0;
    in_weight = '0;
    in_bias   = '0;
    main_err  = 0;
    load_patterns();
    n_words = exp_word.size();
    loaded  = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (4) begin                    // idle, nothing sent yet
      @(negedge clk);
      if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
        $display("error reset_idle: expected valid 0 ready 1 actual %b %b",
                 out_valid, in_ready);
        main_err++;
      end
    end
    @(posedge clk);
    #1;
    drive_taps();
    wait (rcv_cnt >= n_words);
    repeat (20) @(posedge clk);         // a stray extra word shows up here
    $display("pattern and idle errors %0d, output errors %0d, words %0d of %0d",
             main_err, mon_err, rcv_cnt, n_words);
    if (main_err == 0 && mon_err == 0 && rcv_cnt == n_words) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verification/conv_patterns.txt
# w lines hold nine features, nine weights and the bias, as hex bytes
# e lines hold the word name and the expected word in hex, pixel 0 in bits 7:0
w 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 00
w 10 10 10 10 10 10 10 10 10 08 08 08 08 08 08 08 08 08 00
w 01 02 03 04 05 06 07 08 09 20 20 20 20 20 20 20 20 20 00
w 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
e small_pos 14161209
w 10 10 10 10 10 10 10 10 10 f0 f0 f0 f0 f0 f0 f0 f0 f0 00
w 40 40 40 40 40 40 40 40 40 01 01 01 01 01 01 01 01 01 f0
w 20 20 20 20 20 20 20 20 20 04 04 04 04 04 04 04 04 04 00
w 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 ff
e negative 00120000
w 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 00
w 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 00
w 07 07 07 07 07 07 07 07 07 01 01 01 01 01 01 01 01 01 7f
w 00 00 00 00 00 00 00 00 00 05 05 05 05 05 05 05 05 05 7e
e saturate 7e7f7f7f
w 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 05
w 01 02 03 04 05 06 07 08 09 20 20 20 20 20 20 20 20 20 0a
w 10 10 10 10 10 10 10 10 10 08 08 08 08 08 08 08 08 08 64
w 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 01
e bias_lift 1576200e
w 08 10 18 20 28 30 38 40 48 09 08 07 06 05 04 03 02 01 00
w 7f 80 7f 80 7f 80 7f 80 7f 01 01 01 01 01 01 01 01 01 02
w 80 80 80 80 80 80 80 80 80 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
w f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 fe
e mixed 22000314

// File: list.f
logic/conv_pkg.sv
logic/acc_stream_if.sv
logic/signed_mult_pipe.sv
logic/mac_pipeline.sv
logic/acc_fifo.sv
logic/requant_packer.sv
logic/conv_mac_core.sv
verification/tb_conv_mac_core.sv

// File: Makefile
# Verilator simulation of the conv MAC core testbench
VERILATOR ?= verilator
TOP       ?= tb_conv_mac_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
